/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rr_storage_backend
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/rr_params.svh tb/rr_tests.txt

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+verilog
verilog/rr_pkg.sv
verilog/rr_record_packer.sv
verilog/rr_log_buffer.sv
verilog/rr_replay_unpacker.sv
verilog/rr_storage_backend.sv
tb/tb_rr_storage_backend.sv

/* tb/rr_tests.txt */
// Test count, then per test: unit count, expected stored words, back-pressure flag,
// followed by one line per unit: logb_valid loge_valid logb_data (ch2 ch1 ch0)
4
// Mixed bitmaps, invalid slots hold nonzero data
4 5 0
7 3 00112233445566
1 0 FFFFFFFFFFFFAB
0 2 123456789ABCDE
6 1 CAFEF00DBEEF12
// Random ready gaps
5 7 1
2 1 A5A5A5A5A5A5A5
4 0 89ABCDEF000000
3 3 0000000055AA77
5 2 DEADBEEF00F00D
7 0 01020304050607
// Full units back to back
3 6 1
7 1 0F0E0D0C0B0A09
7 2 11111111111111
7 3 FEDCBA98765432
// Every bitmap but the full one
6 5 0
3 1 77665544332211
0 0 FFFFFFFFFFFFFF
5 3 AABBCCDDEEFF00
2 2 0000000000BEEF
4 1 FFFFFFFF123456
1 0 0000000000005A

/* tb/tb_rr_storage_backend.sv */
`timescale 1ns/1ps
`include "rr_params.svh"

module tb_rr_storage_backend;

  localparam int MEM_WORDS = 128;

  logic              clk;
  logic              rst_n;
  logic              record_valid;
  logic              record_ready;
  rr_pkg::rr_unit_t  record_unit;
  logic              flush;
  logic              replay_start;
  logic              replay_valid;
  logic              replay_ready;
  rr_pkg::rr_unit_t  replay_unit;
  logic              replay_done;
  rr_pkg::rr_count_t stored_words;

  // Raw contents of the tests file, one value per entry
  logic [63:0]      tests_mem [MEM_WORDS];
  rr_pkg::rr_unit_t units [$];
  int               errors = 0;
  int               checks = 0;
  int               cycles = 0;
  int               cycle_limit = 0;

  rr_storage_backend dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .record_valid (record_valid),
    .record_ready (record_ready),
    .record_unit  (record_unit),
    .flush        (flush),
    .replay_start (replay_start),
    .replay_valid (replay_valid),
    .replay_ready (replay_ready),
    .replay_unit  (replay_unit),
    .replay_done  (replay_done),
    .stored_words (stored_words)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog, limit set once the tests file is loaded
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // Compacted length, 5 header bits plus each valid slot
  function automatic int unit_bits(logic [`RR_LOGB_CNT-1:0] logb);
    int widths [`RR_LOGB_CNT];
    int bits;
    widths = '{`RR_CH0_W, `RR_CH1_W, `RR_CH2_W};
    bits = `RR_LOGB_CNT + `RR_LOGE_CNT;
    for (int c = 0; c < `RR_LOGB_CNT; c++) begin
      if (logb[c]) bits += widths[c];
    end
    return bits;
  endfunction

  // Replay view of a recorded unit, invalid slots read as zero
  function automatic rr_pkg::rr_unit_t zero_invalid(rr_pkg::rr_unit_t u);
    rr_pkg::rr_unit_t r;
    r = u;
    if (!u.logb_valid[0]) r.logb_data[`RR_CH0_W-1:0] = '0;
    if (!u.logb_valid[1]) r.logb_data[`RR_CH0_W+`RR_CH1_W-1:`RR_CH0_W] = '0;
    if (!u.logb_valid[2]) r.logb_data[`RR_DATA_W-1:`RR_CH0_W+`RR_CH1_W] = '0;
    return r;
  endfunction

  // Ready roughly two cycles in three under back-pressure
  function automatic logic pick_ready(bit bp);
    if (!bp) return 1'b1;
    return ($urandom % 3) != 0;
  endfunction

  task automatic compare_hex(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n = 1'b0;
    record_valid = 1'b0;
    flush = 1'b0;
    replay_start = 1'b0;
    replay_ready = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    compare_hex("record_ready", 64'(record_ready), 64'd1);
    compare_hex("replay_valid", 64'(replay_valid), 64'd0);
    compare_hex("replay_done", 64'(replay_done), 64'd0);
    compare_hex("stored_words", 64'(stored_words), 64'd0);
  endtask

  // One unit per handshake, then a flush pulse
  task automatic record_units(int first, int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      record_valid = 1'b1;
      record_unit = units[first + i];
      // Ready is settled mid-cycle
      do begin
        @(negedge clk);
      end while (!record_ready);
    end
    @(posedge clk);
    #2;
    record_valid = 1'b0;
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
  endtask

  task automatic check_word_count(int exp_words);
    int waited;
    waited = 0;
    while (int'(stored_words) != exp_words && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    // Extra cycles catch any stray write after the tail word
    repeat (2) @(negedge clk);
    compare_hex("stored_words", 64'(stored_words), 64'(exp_words));
  endtask

  task automatic replay_and_check(int first, int n, bit bp);
    int got;
    bit held;
    bit finished;
    rr_pkg::rr_unit_t held_unit;
    rr_pkg::rr_unit_t exp;
    got = 0;
    held = 1'b0;
    finished = 1'b0;
    @(posedge clk);
    #2;
    replay_start = 1'b1;
    replay_ready = pick_ready(bp);
    @(posedge clk);
    #2;
    replay_start = 1'b0;
    while (!finished) begin
      @(negedge clk);
      if (replay_done) begin
        // Done must follow the last transfer, never precede it
        finished = 1'b1;
        compare_hex("replayed unit count", 64'(got), 64'(n));
      end else if (replay_valid) begin
        if (held) compare_hex("held replay_unit", 64'(replay_unit), 64'(held_unit));
        held = 1'b0;
        if (!replay_ready) begin
          held = 1'b1;
          held_unit = replay_unit;
        end else if (got < n) begin
          exp = zero_invalid(units[first + got]);
          compare_hex("replay_unit.logb_valid", 64'(replay_unit.logb_valid),
                      64'(exp.logb_valid));
          compare_hex("replay_unit.loge_valid", 64'(replay_unit.loge_valid),
                      64'(exp.loge_valid));
          compare_hex("replay_unit.logb_data", 64'(replay_unit.logb_data),
                      64'(exp.logb_data));
          got++;
        end else begin
          errors++;
          $display("Replay emitted more units than were recorded");
        end
      end else if (held) begin
        errors++;
        held = 1'b0;
        $display("replay_valid dropped before its unit was taken");
      end
      if (!finished) begin
        @(posedge clk);
        #2;
        replay_ready = pick_ready(bp);
      end
    end
  endtask

  initial begin
    int idx;
    int t;
    int i;
    int n_tests;
    int n_units;
    int exp_words;
    int sum_bits;
    int first;
    int total;
    bit bp;
    rr_pkg::rr_unit_t u;
    void'($urandom(32'h3451));
    rst_n = 1'b0;
    record_valid = 1'b0;
    record_unit = '0;
    flush = 1'b0;
    replay_start = 1'b0;
    replay_ready = 1'b0;
    $readmemh("tb/rr_tests.txt", tests_mem);
    n_tests = int'(tests_mem[0]);
    // First pass only sizes the watchdog
    idx = 1;
    total = 0;
    for (t = 0; t < n_tests; t++) begin
      n_units = int'(tests_mem[idx]);
      total += n_units;
      idx += 3 + 3 * n_units;
    end
    cycle_limit = 200 * total + 1000;
    idx = 1;
    for (t = 0; t < n_tests; t++) begin
      n_units = int'(tests_mem[idx]);
      exp_words = int'(tests_mem[idx + 1]);
      bp = tests_mem[idx + 2][0];
      idx += 3;
      first = units.size();
      sum_bits = 0;
      for (i = 0; i < n_units; i++) begin
        u.logb_valid = tests_mem[idx][`RR_LOGB_CNT-1:0];
        u.loge_valid = tests_mem[idx + 1][`RR_LOGE_CNT-1:0];
        u.logb_data = tests_mem[idx + 2][`RR_DATA_W-1:0];
        units.push_back(u);
        sum_bits += unit_bits(u.logb_valid);
        idx += 3;
      end
      // File value against the length rule, rounded up to whole words
      compare_hex("tests file word count", 64'(exp_words), 64'((sum_bits + 31) / 32));
      // No restart in the design, so each test gets a fresh reset
      apply_reset();
      record_units(first, n_units);
      check_word_count(exp_words);
      replay_and_check(first, n_units, bp);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog/rr_log_buffer.sv */
`timescale 1ns/1ps
`include "rr_params.svh"

module rr_log_buffer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_en,
  input  rr_pkg::rr_word_t  wr_word,
  output logic              buf_full,
  input  logic              replay_start,
  input  logic              rd_en,
  output rr_pkg::rr_word_t  rd_word,
  output logic              rd_avail,
  output rr_pkg::rr_count_t stored_words
);

  // On-chip stand-in for external log storage
  rr_pkg::rr_word_t  mem [`RR_BUF_DEPTH];

  // Pointers carry one extra bit so a full buffer is visible
  rr_pkg::rr_count_t wr_cnt;
  rr_pkg::rr_count_t rd_cnt;
  rr_pkg::rr_addr_t  wr_addr;
  rr_pkg::rr_addr_t  rd_addr;
  logic              do_write;

  assign wr_addr = rr_pkg::rr_addr_t'(wr_cnt);
  assign rd_addr = rr_pkg::rr_addr_t'(rd_cnt);

  assign buf_full     = (wr_cnt == rr_pkg::rr_count_t'(`RR_BUF_DEPTH));
  assign stored_words = wr_cnt;
  // Replay may only read what record has written
  assign rd_avail     = (rd_cnt < wr_cnt);

  assign do_write = wr_en && !buf_full;

  // Memory array, read data one cycle after rd_en
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_addr] <= wr_word;
    end
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      rd_cnt <= '0;
    end else begin
      if (do_write) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      // Start of replay rewinds to the first stored word
      if (replay_start) begin
        rd_cnt <= '0;
      end else if (rd_en) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  // Unpacker never reads past the written data
  assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> rd_avail);

endmodule

/* verilog/rr_params.svh */
`ifndef RR_PARAMS_SVH
`define RR_PARAMS_SVH

// Channel counts of one logging unit
`define RR_LOGB_CNT 3
`define RR_LOGE_CNT 2

// Data slot width of each logb channel
`define RR_CH0_W 8
`define RR_CH1_W 16
`define RR_CH2_W 32

// Sum of all slot widths
`define RR_DATA_W 56
// Header bits plus every slot
`define RR_UNIT_W 61

// Storage word and on-chip buffer size
`define RR_WORD_W 32
`define RR_BUF_DEPTH 64

// Packer and unpacker bit accumulator width
`define RR_ACC_W 96

`endif

/* verilog/rr_pkg.sv */
`include "rr_params.svh"

package rr_pkg;

  // Storage side widths
  typedef logic [`RR_WORD_W-1:0] rr_word_t;
  typedef logic [$clog2(`RR_BUF_DEPTH)-1:0] rr_addr_t;
  typedef logic [$clog2(`RR_BUF_DEPTH+1)-1:0] rr_count_t;

  // Compacted unit length in bits
  typedef logic [6:0] rr_len_t;
  // Number of units recorded or replayed
  typedef logic [15:0] rr_ucount_t;

  // Members run MSB first, so logb_valid sits at bit 0
  typedef struct packed {
    logic [`RR_DATA_W-1:0]   logb_data;
    logic [`RR_LOGE_CNT-1:0] loge_valid;
    logic [`RR_LOGB_CNT-1:0] logb_valid;
  } rr_unit_t;

  typedef enum logic [1:0] {IDLE, FILL, EMIT, DONE} rr_replay_state_t;

  // Header bits plus the width of every valid logb slot
  function automatic rr_len_t rr_get_len(logic [`RR_LOGB_CNT-1:0] logb_bitmap);
    rr_len_t len;
    len = rr_len_t'(`RR_LOGB_CNT + `RR_LOGE_CNT);
    if (logb_bitmap[0])
      len = len + rr_len_t'(`RR_CH0_W);
    if (logb_bitmap[1])
      len = len + rr_len_t'(`RR_CH1_W);
    if (logb_bitmap[2])
      len = len + rr_len_t'(`RR_CH2_W);
    return len;
  endfunction

endpackage

/* verilog/rr_record_packer.sv */
`timescale 1ns/1ps
`include "rr_params.svh"

module rr_record_packer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               record_valid,
  output logic               record_ready,
  input  rr_pkg::rr_unit_t   record_unit,
  input  logic               flush,
  input  logic               buf_full,
  output logic               wr_en,
  output rr_pkg::rr_word_t   wr_word,
  output rr_pkg::rr_ucount_t unit_count
);

  localparam int HDR_W  = `RR_LOGB_CNT + `RR_LOGE_CNT;
  localparam int FILL_W = $clog2(`RR_ACC_W + 1);

  logic [`RR_CH0_W-1:0] ch0_data;
  logic [`RR_CH1_W-1:0] ch1_data;
  logic [`RR_CH2_W-1:0] ch2_data;

  logic [`RR_ACC_W-1:0] comp;
  rr_pkg::rr_len_t      comp_len;

  logic [`RR_ACC_W-1:0] acc;
  logic [`RR_ACC_W-1:0] acc_base;
  logic [`RR_ACC_W-1:0] acc_next;
  logic [FILL_W-1:0]    fill;
  logic [FILL_W-1:0]    fill_base;
  logic [FILL_W-1:0]    fill_next;
  logic                 closing;
  logic                 accept;

  // Slot boundaries inside the data field
  assign ch0_data = record_unit.logb_data[`RR_CH0_W-1:0];
  assign ch1_data = record_unit.logb_data[`RR_CH0_W+`RR_CH1_W-1:`RR_CH0_W];
  assign ch2_data = record_unit.logb_data[`RR_DATA_W-1:`RR_CH0_W+`RR_CH1_W];

  // Compaction puts the header first, then valid slots in channel order
  always_comb begin
    rr_pkg::rr_len_t pos;
    comp = '0;
    comp[HDR_W-1:0] = {record_unit.loge_valid, record_unit.logb_valid};
    pos = rr_pkg::rr_len_t'(HDR_W);
    if (record_unit.logb_valid[0]) begin
      comp[pos +: `RR_CH0_W] = ch0_data;
      pos = pos + rr_pkg::rr_len_t'(`RR_CH0_W);
    end
    if (record_unit.logb_valid[1]) begin
      comp[pos +: `RR_CH1_W] = ch1_data;
      pos = pos + rr_pkg::rr_len_t'(`RR_CH1_W);
    end
    // Last slot needs no position update
    if (record_unit.logb_valid[2]) begin
      comp[pos +: `RR_CH2_W] = ch2_data;
    end
  end

  assign comp_len = rr_pkg::rr_get_len(record_unit.logb_valid);

  // Needs room for a worst-case unit and closes for good on flush
  assign record_ready = !closing && !buf_full &&
                        (fill <= FILL_W'(`RR_ACC_W - `RR_UNIT_W));
  assign accept = record_valid && record_ready;

  // Full words drain, and once closing the zero-padded tail too
  assign wr_en = !buf_full &&
                 ((fill >= FILL_W'(`RR_WORD_W)) || (closing && (fill != '0)));
  // Bits above fill are always zero
  assign wr_word = acc[`RR_WORD_W-1:0];

  always_comb begin
    acc_base  = acc;
    fill_base = fill;
    if (wr_en) begin
      acc_base  = acc >> `RR_WORD_W;
      fill_base = (fill >= FILL_W'(`RR_WORD_W)) ? fill - FILL_W'(`RR_WORD_W) : '0;
    end
    acc_next  = acc_base;
    fill_next = fill_base;
    // Append new unit right above what is left
    if (accept) begin
      acc_next  = acc_base | (comp << fill_base);
      fill_next = fill_base + FILL_W'(comp_len);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc        <= '0;
      fill       <= '0;
      closing    <= 1'b0;
      unit_count <= '0;
    end else begin
      acc  <= acc_next;
      fill <= fill_next;
      if (flush) begin
        closing <= 1'b1;
      end
      if (accept) begin
        unit_count <= unit_count + 1'b1;
      end
    end
  end

  // Accumulator never overruns
  assert property (@(posedge clk) disable iff (!rst_n) fill <= FILL_W'(`RR_ACC_W));
  // A full buffer freezes the accumulator, so no word leaves for it
  assert property (@(posedge clk) disable iff (!rst_n)
    buf_full |=> $stable(fill) && $stable(acc));

endmodule

/* verilog/rr_replay_unpacker.sv */
`timescale 1ns/1ps
`include "rr_params.svh"

module rr_replay_unpacker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               replay_start,
  input  rr_pkg::rr_ucount_t unit_count,
  input  logic               rd_avail,
  output logic               rd_en,
  input  rr_pkg::rr_word_t   rd_word,
  output logic               replay_valid,
  input  logic               replay_ready,
  output rr_pkg::rr_unit_t   replay_unit,
  output logic               replay_done
);

  localparam int HDR_W  = `RR_LOGB_CNT + `RR_LOGE_CNT;
  localparam int FILL_W = $clog2(`RR_ACC_W + 1);

  rr_pkg::rr_replay_state_t state;
  logic [`RR_ACC_W-1:0]     acc;
  logic [`RR_ACC_W-1:0]     acc_base;
  logic [`RR_ACC_W-1:0]     acc_next;
  logic [FILL_W-1:0]        fill;
  logic [FILL_W-1:0]        fill_base;
  logic [FILL_W-1:0]        fill_next;
  logic                     rd_pend;
  logic                     room;
  logic                     active;
  logic                     unit_ok;
  logic                     take;
  rr_pkg::rr_len_t          unit_len;
  rr_pkg::rr_ucount_t       emitted;

  assign active = (state == rr_pkg::FILL) || (state == rr_pkg::EMIT);

  // Length of the unit at the accumulator head, from its logb bitmap
  assign unit_len = rr_pkg::rr_get_len(acc[`RR_LOGB_CNT-1:0]);
  // Header must be in before the length means anything
  assign unit_ok  = (fill >= FILL_W'(HDR_W)) && (fill >= FILL_W'(unit_len));

  // Space for one more word, counting a read still in flight
  assign room  = rd_pend ? (fill <= FILL_W'(`RR_ACC_W - 2 * `RR_WORD_W))
                         : (fill <= FILL_W'(`RR_ACC_W - `RR_WORD_W));
  assign rd_en = active && rd_avail && room;

  assign replay_valid = (state == rr_pkg::EMIT);
  assign take         = replay_valid && replay_ready;
  assign replay_done  = (state == rr_pkg::DONE);

  // Expand to full layout, slots of clear logb bits stay zero
  always_comb begin
    rr_pkg::rr_len_t pos;
    replay_unit = '0;
    replay_unit.logb_valid = acc[`RR_LOGB_CNT-1:0];
    replay_unit.loge_valid = acc[HDR_W-1:`RR_LOGB_CNT];
    pos = rr_pkg::rr_len_t'(HDR_W);
    if (acc[0]) begin
      replay_unit.logb_data[`RR_CH0_W-1:0] = acc[pos +: `RR_CH0_W];
      pos = pos + rr_pkg::rr_len_t'(`RR_CH0_W);
    end
    if (acc[1]) begin
      replay_unit.logb_data[`RR_CH0_W+`RR_CH1_W-1:`RR_CH0_W] = acc[pos +: `RR_CH1_W];
      pos = pos + rr_pkg::rr_len_t'(`RR_CH1_W);
    end
    if (acc[2]) begin
      replay_unit.logb_data[`RR_DATA_W-1:`RR_CH0_W+`RR_CH1_W] = acc[pos +: `RR_CH2_W];
    end
  end

  // Consume the emitted unit, then land an arriving word above the rest
  // Arrivals only touch bits above fill, so the presented unit holds still
  always_comb begin
    acc_base  = acc;
    fill_base = fill;
    if (take) begin
      acc_base  = acc >> unit_len;
      fill_base = fill - FILL_W'(unit_len);
    end
    acc_next  = acc_base;
    fill_next = fill_base;
    if (rd_pend) begin
      acc_next  = acc_base | ({{(`RR_ACC_W - `RR_WORD_W){1'b0}}, rd_word} << fill_base);
      fill_next = fill_base + FILL_W'(`RR_WORD_W);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= rr_pkg::IDLE;
      acc     <= '0;
      fill    <= '0;
      rd_pend <= 1'b0;
      emitted <= '0;
    end else begin
      rd_pend <= rd_en;
      if (active) begin
        acc  <= acc_next;
        fill <= fill_next;
      end
      case (state)
        rr_pkg::IDLE: begin
          if (replay_start) begin
            acc     <= '0;
            fill    <= '0;
            emitted <= '0;
            // Nothing recorded means nothing to replay
            state   <= (unit_count == '0) ? rr_pkg::DONE : rr_pkg::FILL;
          end
        end
        rr_pkg::FILL: begin
          if (unit_ok) begin
            state <= rr_pkg::EMIT;
          end
        end
        rr_pkg::EMIT: begin
          if (take) begin
            emitted <= emitted + 1'b1;
            // Stop right after the last recorded unit
            state   <= (emitted + 1'b1 == unit_count) ? rr_pkg::DONE : rr_pkg::FILL;
          end
        end
        default: begin
          state <= rr_pkg::DONE;
        end
      endcase
    end
  end

  // Held unit stays put under back-pressure
  assert property (@(posedge clk) disable iff (!rst_n)
    replay_valid && !replay_ready |=> replay_valid && $stable(replay_unit));

endmodule

/* verilog/rr_storage_backend.sv */
`timescale 1ns/1ps

module rr_storage_backend (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              record_valid,
  output logic              record_ready,
  input  rr_pkg::rr_unit_t  record_unit,
  input  logic              flush,
  input  logic              replay_start,
  output logic              replay_valid,
  input  logic              replay_ready,
  output rr_pkg::rr_unit_t  replay_unit,
  output logic              replay_done,
  output rr_pkg::rr_count_t stored_words
);

  // Packer to buffer
  logic               wr_en;
  rr_pkg::rr_word_t   wr_word;
  logic               buf_full;

  // Buffer to unpacker
  logic               rd_en;
  rr_pkg::rr_word_t   rd_word;
  logic               rd_avail;

  // Units recorded, stable once flushed
  rr_pkg::rr_ucount_t unit_count;

  // Record side
  rr_record_packer packer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .record_valid (record_valid),
    .record_ready (record_ready),
    .record_unit  (record_unit),
    .flush        (flush),
    .buf_full     (buf_full),
    .wr_en        (wr_en),
    .wr_word      (wr_word),
    .unit_count   (unit_count)
  );

  rr_log_buffer buffer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_word      (wr_word),
    .buf_full     (buf_full),
    .replay_start (replay_start),
    .rd_en        (rd_en),
    .rd_word      (rd_word),
    .rd_avail     (rd_avail),
    .stored_words (stored_words)
  );

  // Replay side
  rr_replay_unpacker unpacker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .replay_start (replay_start),
    .unit_count   (unit_count),
    .rd_avail     (rd_avail),
    .rd_en        (rd_en),
    .rd_word      (rd_word),
    .replay_valid (replay_valid),
    .replay_ready (replay_ready),
    .replay_unit  (replay_unit),
    .replay_done  (replay_done)
  );

endmodule
